/* src/cache_config.svh */
// geometry of the four-way read cache, CPU and DRAM bus widths
// and the CAS latency of the DRAM controller

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////
`define CACHE_WAYS 4		// ways per set
`define CACHE_LINES 8		// lines (sets) per way
`define LINE_WORDS 8		// sixteen-bit words per line

//////////////////////////////////////////////////
// bus widths and DRAM timing
//////////////////////////////////////////////////
`define ADDR_WIDTH 32		// 68000 byte address
`define DATA_WIDTH 16		// one bus word
`define CAS_LATENCY 2		// clocks from the read CAS edge to the first burst word

`endif

/* src/cacheGeometryPkg.sv */
// vector types for addresses, data words, tags, indices, word selects and ways,
// plus the helpers that slice a CPU address into tag, index and word

`include "cache_config.svh"

package cacheGeometryPkg;
	localparam int WordBits = $clog2(`LINE_WORDS);		// word select within a line
	localparam int IndexBits = $clog2(`CACHE_LINES);	// line index
	localparam int TagBits = `ADDR_WIDTH - IndexBits - WordBits - 1;	// bit 0 is the byte lane
	localparam int WayBits = $clog2(`CACHE_WAYS);		// encoded way number

	typedef logic [`ADDR_WIDTH-1:0] addrT;
	typedef logic [`DATA_WIDTH-1:0] dataT;
	typedef logic [TagBits-1:0] tagT;
	typedef logic [IndexBits-1:0] indexT;
	typedef logic [WordBits-1:0] wordSelT;
	typedef logic [WayBits-1:0] wayT;
	typedef logic [`CACHE_WAYS-1:0] waySetT;

	function automatic tagT addrTag(addrT addr);
		return addr[`ADDR_WIDTH-1 -: TagBits];		// everything above the index
	endfunction

	function automatic indexT addrIndex(addrT addr);
		return addr[WordBits+1 +: IndexBits];		// bits 6 down to 4
	endfunction

	function automatic wordSelT addrWord(addrT addr);
		return addr[1 +: WordBits];		// bits 3 down to 1
	endfunction
endpackage

/* src/cacheControlPkg.sv */
// sequencer state encoding and the per-line pseudo-LRU tree type

`include "cache_config.svh"

package cacheControlPkg;
	typedef enum logic [3:0] {
		Flush,		// sweeping the lines after reset
		Idle,		// waiting for a CPU cycle
		LookUp,		// tag compare on a read
		HitHold,	// acknowledge held until the CPU ends the cycle
		FillRequest,	// DRAM selected, waiting for the read CAS
		CasWait,	// counting out the CAS latency
		BurstFill,	// eight words land in the victim way
		FillDone,	// line complete, acknowledge the CPU
		WriteThrough	// write passed on to DRAM
	} seqStateT;

	typedef logic [`CACHE_WAYS-2:0] lruT;	// one bit per tree node
endpackage

/* src/cacheSequencer.sv */
// control FSM of the read cache: flush sweep, hit and miss handling,
// burst counter, victim register, DRAM bus steering and CPU acknowledge

`timescale 1ns/10ps
`include "cache_config.svh"

module cacheSequencer (
	input logic Clock,
	input logic Reset_L,
	input logic CpuAs_L,
	input logic CpuWe_L,
	input logic CpuUds_L,
	input logic CpuLds_L,
	input logic CpuDramSelect,
	input cacheGeometryPkg::addrT CpuAddress,
	input cacheGeometryPkg::waySetT HitWays,
	input cacheGeometryPkg::wayT Victim,
	input logic DramDtack_L,
	input logic DramCas_L,
	input logic DramRas_L,
	output logic CpuDtack_L,
	output logic DramSelect_L,
	output logic DramUds_L,
	output logic DramLds_L,
	output logic DramAs_L,
	output logic DramWe_L,
	output cacheGeometryPkg::addrT DramAddress,
	output logic FlushActive,
	output cacheGeometryPkg::indexT FlushIndex,
	output logic TagLoad,
	output logic InvalidateHit,
	output cacheGeometryPkg::wayT FillWay,
	output logic FillLoad,
	output cacheGeometryPkg::wordSelT FillWord,
	output logic Touch,
	output cacheGeometryPkg::wayT TouchWay
);
	// the counter covers both the flush sweep and the burst words
	localparam int CountBits = (cacheGeometryPkg::WordBits > cacheGeometryPkg::IndexBits) ?
		cacheGeometryPkg::WordBits : cacheGeometryPkg::IndexBits;

	cacheControlPkg::seqStateT state;		// current FSM state
	cacheControlPkg::seqStateT nextState;		// state after the next edge
	logic [CountBits-1:0] burstCount;		// lines swept or words filled so far
	cacheGeometryPkg::wayT victimWay;		// way chosen for the fill in progress
	cacheGeometryPkg::wayT hitWay;			// encoded form of HitWays
	logic cycleStart;				// CPU has started a DRAM-space cycle
	logic cycleEnd;					// CPU has dropped AS or the select
	logic readCycle;				// forces both DRAM strobes and a line address
	logic lastWord;					// final word of the burst is on the bus

	assign cycleStart = !CpuAs_L && CpuDramSelect;
	assign cycleEnd = CpuAs_L || !CpuDramSelect;
	assign lastWord = (state == cacheControlPkg::BurstFill) &&
		(burstCount == CountBits'(`LINE_WORDS - 1));

	//////////////////////////////////////////////////
	// state, counter and victim registers
	//////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= cacheControlPkg::Flush;	// every line is swept after reset
			burstCount <= '0;
		end else begin
			state <= nextState;
			if (state != nextState)
				burstCount <= '0;		// each state starts counting from zero
			else
				burstCount <= burstCount + 1'b1;
		end
	end

	always_ff @(posedge Clock) begin
		if (state == cacheControlPkg::LookUp && HitWays == '0)
			victimWay <= Victim;		// LRU choice is frozen for the whole fill
	end

	always_comb begin
		hitWay = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (HitWays[w])
				hitWay = cacheGeometryPkg::wayT'(w);	// at most one way can hit
		end
	end

	//////////////////////////////////////////////////
	// next state and cache store controls
	//////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		CpuDtack_L = 1'b1;
		DramSelect_L = 1'b1;
		TagLoad = 1'b0;
		InvalidateHit = 1'b0;
		FillLoad = 1'b0;
		Touch = 1'b0;
		case (state)
			cacheControlPkg::Flush: begin
				if (burstCount == CountBits'(`CACHE_LINES - 1))
					nextState = cacheControlPkg::Idle;	// last line cleared
			end
			cacheControlPkg::Idle: begin
				if (cycleStart && CpuWe_L) begin
					nextState = cacheControlPkg::LookUp;	// a read, check the tags first
				end else if (cycleStart) begin
					DramSelect_L = 1'b0;		// writes always go to DRAM
					InvalidateHit = 1'b1;		// a stale copy must not survive
					nextState = cacheControlPkg::WriteThrough;
				end
			end
			cacheControlPkg::LookUp: begin
				if (HitWays != '0) begin
					CpuDtack_L = 1'b0;		// data is already on CpuReadData
					Touch = 1'b1;
					nextState = cacheControlPkg::HitHold;
				end else begin
					DramSelect_L = 1'b0;		// miss, start the line read
					nextState = cacheControlPkg::FillRequest;
				end
			end
			cacheControlPkg::HitHold: begin
				CpuDtack_L = 1'b0;
				if (cycleEnd)
					nextState = cacheControlPkg::Idle;
			end
			cacheControlPkg::FillRequest: begin
				DramSelect_L = 1'b0;
				if (!DramCas_L && DramRas_L)
					nextState = cacheControlPkg::CasWait;	// read command, not a refresh
			end
			cacheControlPkg::CasWait: begin
				DramSelect_L = 1'b0;
				if (burstCount == CountBits'(`CAS_LATENCY - 2))
					nextState = cacheControlPkg::BurstFill;	// first word arrives next edge
			end
			cacheControlPkg::BurstFill: begin
				DramSelect_L = 1'b0;
				FillLoad = 1'b1;
				if (lastWord) begin
					TagLoad = 1'b1;			// line becomes valid with its last word
					Touch = 1'b1;
					nextState = cacheControlPkg::FillDone;
				end
			end
			cacheControlPkg::FillDone: begin
				CpuDtack_L = 1'b0;			// the filled way now hits
				if (cycleEnd)
					nextState = cacheControlPkg::Idle;
			end
			cacheControlPkg::WriteThrough: begin
				DramSelect_L = 1'b0;
				CpuDtack_L = DramDtack_L;		// the DRAM decides when the write is done
				if (cycleEnd)
					nextState = cacheControlPkg::Idle;
			end
			default: nextState = cacheControlPkg::Flush;
		endcase
	end

	//////////////////////////////////////////////////
	// DRAM bus steering
	//////////////////////////////////////////////////
	assign readCycle = (state inside {cacheControlPkg::LookUp, cacheControlPkg::HitHold,
		cacheControlPkg::FillRequest, cacheControlPkg::CasWait, cacheControlPkg::BurstFill,
		cacheControlPkg::FillDone}) || (state == cacheControlPkg::Idle && cycleStart && CpuWe_L);

	assign DramUds_L = readCycle ? 1'b0 : CpuUds_L;	// whole words are fetched on a read
	assign DramLds_L = readCycle ? 1'b0 : CpuLds_L;
	assign DramAddress = readCycle ? {CpuAddress[`ADDR_WIDTH-1:4], 4'b0000} : CpuAddress;
	assign DramAs_L = CpuAs_L;
	assign DramWe_L = CpuWe_L;

	assign FlushActive = (state == cacheControlPkg::Flush);
	assign FlushIndex = cacheGeometryPkg::indexT'(burstCount);
	assign FillWay = victimWay;
	assign FillWord = cacheGeometryPkg::wordSelT'(burstCount);	// burst arrives in word order
	assign TouchWay = (state == cacheControlPkg::LookUp) ? hitWay : victimWay;

	// acknowledge only ever comes from a hit, a finished fill or a DRAM write
	dtackStates: assert property (@(posedge Clock) disable iff (!Reset_L)
		!CpuDtack_L |-> state inside {cacheControlPkg::LookUp, cacheControlPkg::HitHold,
			cacheControlPkg::FillDone, cacheControlPkg::WriteThrough});

	// DRAM stays untouched while the tags are still being cleared
	noSelectInFlush: assert property (@(posedge Clock) disable iff (!Reset_L)
		state == cacheControlPkg::Flush |-> DramSelect_L);
endmodule

/* src/tagStore.sv */
// tag and valid arrays for every way and line, with flush, fill and
// write-hit invalidation, and the combinational hit compare

`timescale 1ns/10ps
`include "cache_config.svh"

module tagStore (
	input logic Clock,
	input cacheGeometryPkg::addrT CpuAddress,
	input logic FlushActive,
	input cacheGeometryPkg::indexT FlushIndex,
	input logic TagLoad,
	input cacheGeometryPkg::wayT FillWay,
	input logic InvalidateHit,
	output cacheGeometryPkg::waySetT HitWays
);
	cacheGeometryPkg::tagT tagMem [`CACHE_WAYS][`CACHE_LINES];	// stored address tags
	logic validMem [`CACHE_WAYS][`CACHE_LINES];			// line holds good data
	cacheGeometryPkg::indexT lineIndex;				// line addressed by the CPU
	cacheGeometryPkg::tagT cpuTag;					// tag part of the CPU address

	assign lineIndex = cacheGeometryPkg::addrIndex(CpuAddress);
	assign cpuTag = cacheGeometryPkg::addrTag(CpuAddress);

	always_ff @(posedge Clock) begin
		if (FlushActive) begin
			for (int w = 0; w < `CACHE_WAYS; w++)
				validMem[w][FlushIndex] <= 1'b0;	// one whole set per clock
		end else if (TagLoad) begin
			tagMem[FillWay][lineIndex] <= cpuTag;
			validMem[FillWay][lineIndex] <= 1'b1;
		end else if (InvalidateHit) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (HitWays[w])
					validMem[w][lineIndex] <= 1'b0;	// written word is now stale here
			end
		end
	end

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++)
			HitWays[w] = validMem[w][lineIndex] && (tagMem[w][lineIndex] == cpuTag);
	end

	// fills only follow a miss, so a tag never sits in two ways of a set
	singleHit: assert property (@(posedge Clock) disable iff (FlushActive)
		$onehot0(HitWays));
endmodule

/* src/lineStore.sv */
// data words of every way and line: burst writes from DRAM
// and the CPU read word taken from the hitting way

`timescale 1ns/10ps
`include "cache_config.svh"

module lineStore (
	input logic Clock,
	input cacheGeometryPkg::addrT CpuAddress,
	input cacheGeometryPkg::wayT FillWay,
	input cacheGeometryPkg::wordSelT FillWord,
	input logic FillLoad,
	input cacheGeometryPkg::dataT DramReadData,
	input cacheGeometryPkg::waySetT HitWays,
	output cacheGeometryPkg::dataT CpuReadData
);
	cacheGeometryPkg::dataT dataMem [`CACHE_WAYS][`CACHE_LINES][`LINE_WORDS];
	cacheGeometryPkg::indexT lineIndex;		// line addressed by the CPU

	assign lineIndex = cacheGeometryPkg::addrIndex(CpuAddress);

	always_ff @(posedge Clock) begin
		if (FillLoad)
			dataMem[FillWay][lineIndex][FillWord] <= DramReadData;	// one burst word per clock
	end

	always_comb begin
		CpuReadData = '0;		// zero when nothing hits
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (HitWays[w])
				CpuReadData = dataMem[w][lineIndex][cacheGeometryPkg::addrWord(CpuAddress)];
		end
	end
endmodule

/* src/lruTree.sv */
// three-bit pseudo-LRU tree per line: cleared by the flush, read out as
// the victim way, and pointed away from each way that is accessed

`timescale 1ns/10ps
`include "cache_config.svh"

module lruTree (
	input logic Clock,
	input cacheGeometryPkg::addrT CpuAddress,
	input logic FlushActive,
	input cacheGeometryPkg::indexT FlushIndex,
	input logic Touch,
	input cacheGeometryPkg::wayT TouchWay,
	output cacheGeometryPkg::wayT Victim
);
	cacheControlPkg::lruT lruMem [`CACHE_LINES];	// tree bits per line
	cacheGeometryPkg::indexT lineIndex;		// line addressed by the CPU
	cacheControlPkg::lruT lruBits;			// tree of the addressed line
	cacheControlPkg::lruT lruNext;			// tree after touching TouchWay

	assign lineIndex = cacheGeometryPkg::addrIndex(CpuAddress);
	assign lruBits = lruMem[lineIndex];

	// bit 0 picks the half, bit 1 or bit 2 picks the way inside it
	assign Victim = lruBits[0] ? {1'b1, lruBits[2]} : {1'b0, lruBits[1]};

	always_comb begin
		lruNext = lruBits;
		lruNext[0] = !TouchWay[1];		// point at the other half
		if (TouchWay[1])
			lruNext[2] = !TouchWay[0];	// sibling of way 2 or 3
		else
			lruNext[1] = !TouchWay[0];	// sibling of way 0 or 1
	end

	always_ff @(posedge Clock) begin
		if (FlushActive)
			lruMem[FlushIndex] <= '0;		// fresh line starts with way 0
		else if (Touch)
			lruMem[lineIndex] <= lruNext;
	end
endmodule

/* src/cacheController.sv */
// top level of the read cache: the sequencer with the tag, line and LRU stores,
// seen from outside as the CPU bus and the DRAM controller bus

`timescale 1ns/10ps

module cacheController (
	input logic Clock,
	input logic Reset_L,
	input logic CpuAs_L,
	input logic CpuWe_L,
	input logic CpuUds_L,
	input logic CpuLds_L,
	input logic CpuDramSelect,
	input cacheGeometryPkg::addrT CpuAddress,
	input cacheGeometryPkg::dataT CpuWriteData,
	output cacheGeometryPkg::dataT CpuReadData,
	output logic CpuDtack_L,
	output logic DramSelect_L,
	output cacheGeometryPkg::addrT DramAddress,
	output cacheGeometryPkg::dataT DramWriteData,
	output logic DramWe_L,
	output logic DramAs_L,
	output logic DramUds_L,
	output logic DramLds_L,
	input cacheGeometryPkg::dataT DramReadData,
	input logic DramDtack_L,
	input logic DramCas_L,
	input logic DramRas_L
);
	logic flushActive;
	cacheGeometryPkg::indexT flushIndex;
	logic tagLoad;
	logic invalidateHit;
	cacheGeometryPkg::wayT fillWay;
	logic fillLoad;
	cacheGeometryPkg::wordSelT fillWord;
	logic touch;
	cacheGeometryPkg::wayT touchWay;
	cacheGeometryPkg::waySetT hitWays;
	cacheGeometryPkg::wayT victim;

	assign DramWriteData = CpuWriteData;		// writes are never held in the cache

	cacheSequencer sequencer (.Clock(Clock), .Reset_L(Reset_L), .CpuAs_L(CpuAs_L),
		.CpuWe_L(CpuWe_L), .CpuUds_L(CpuUds_L), .CpuLds_L(CpuLds_L),
		.CpuDramSelect(CpuDramSelect), .CpuAddress(CpuAddress), .HitWays(hitWays),
		.Victim(victim), .DramDtack_L(DramDtack_L), .DramCas_L(DramCas_L),
		.DramRas_L(DramRas_L), .CpuDtack_L(CpuDtack_L), .DramSelect_L(DramSelect_L),
		.DramUds_L(DramUds_L), .DramLds_L(DramLds_L), .DramAs_L(DramAs_L),
		.DramWe_L(DramWe_L), .DramAddress(DramAddress), .FlushActive(flushActive),
		.FlushIndex(flushIndex), .TagLoad(tagLoad), .InvalidateHit(invalidateHit),
		.FillWay(fillWay), .FillLoad(fillLoad), .FillWord(fillWord), .Touch(touch),
		.TouchWay(touchWay));

	tagStore tags (.Clock(Clock), .CpuAddress(CpuAddress), .FlushActive(flushActive),
		.FlushIndex(flushIndex), .TagLoad(tagLoad), .FillWay(fillWay),
		.InvalidateHit(invalidateHit), .HitWays(hitWays));

	lineStore lines (.Clock(Clock), .CpuAddress(CpuAddress), .FillWay(fillWay),
		.FillWord(fillWord), .FillLoad(fillLoad), .DramReadData(DramReadData),
		.HitWays(hitWays), .CpuReadData(CpuReadData));

	lruTree lru (.Clock(Clock), .CpuAddress(CpuAddress), .FlushActive(flushActive),
		.FlushIndex(flushIndex), .Touch(touch), .TouchWay(touchWay), .Victim(victim));
endmodule

/* tests/dramModel.sv */
// behavioral DRAM controller for the cache testbench
// read bursts of one line after a CAS pulse, word writes held in an associative array

`timescale 1ns/10ps
`include "cache_config.svh"

module dramModel (
	input logic Clock,
	input logic DramSelect_L,
	input cacheGeometryPkg::addrT DramAddress,
	input cacheGeometryPkg::dataT DramWriteData,
	input logic DramWe_L,
	output cacheGeometryPkg::dataT DramReadData,
	output logic DramDtack_L,
	output logic DramCas_L,
	output logic DramRas_L
);
	localparam int SelectTimeout = 64;		// clocks before the model stops waiting on a select

	cacheGeometryPkg::dataT store [cacheGeometryPkg::addrT];	// words written through
	cacheGeometryPkg::addrT lineBase;		// first word of the line being burst
	int waitCount;					// clocks spent waiting for the select to rise

	// unwritten words follow a pattern of the whole address
	function automatic cacheGeometryPkg::dataT wordAt(input cacheGeometryPkg::addrT addr);
		if (store.exists(addr))
			return store[addr];
		return cacheGeometryPkg::dataT'(addr[31:16] ^ addr[15:0] ^ 16'h3C5A);
	endfunction

	initial begin
		DramReadData <= '0;
		DramDtack_L <= 1'b1;
		DramCas_L <= 1'b1;
		DramRas_L <= 1'b1;		// never a refresh, so every CAS is a read command
	end

	always begin
		@(posedge Clock);
		if (!DramSelect_L && DramWe_L) begin
			lineBase = DramAddress;
			repeat (2) @(posedge Clock);		// row access before the column strobe
			DramCas_L <= 1'b0;
			@(posedge Clock);
			DramCas_L <= 1'b1;			// the cache has seen the read command here
			repeat (`CAS_LATENCY - 1) @(posedge Clock);
			for (int k = 0; k < `LINE_WORDS; k++) begin
				DramReadData <= wordAt(cacheGeometryPkg::addrT'(lineBase + 2 * k));
				@(posedge Clock);		// one burst word per clock
			end
			waitCount = 0;
			while (!DramSelect_L && waitCount < SelectTimeout) begin
				@(posedge Clock);
				waitCount++;
			end
		end else if (!DramSelect_L) begin
			store[{DramAddress[`ADDR_WIDTH-1:1], 1'b0}] = DramWriteData;
			repeat (2) @(posedge Clock);		// write recovery before the acknowledge
			DramDtack_L <= 1'b0;
			waitCount = 0;
			while (!DramSelect_L && waitCount < SelectTimeout) begin
				@(posedge Clock);
				waitCount++;
			end
			DramDtack_L <= 1'b1;
		end
	end
endmodule

/* tests/cacheControllerTb.sv */
// testbench of the four-way read cache: clock, reset, CPU bus cycles
// against the DRAM model, checking assertions and the closing summary

`timescale 1ns/10ps
`include "cache_config.svh"

module cacheControllerTb;
	localparam int AckTimeout = 100;		// clocks allowed for any acknowledge

	logic Clock;
	logic Reset_L;
	logic CpuAs_L, CpuWe_L, CpuUds_L, CpuLds_L, CpuDramSelect;
	cacheGeometryPkg::addrT CpuAddress;
	cacheGeometryPkg::dataT CpuWriteData;
	cacheGeometryPkg::dataT CpuReadData;
	logic CpuDtack_L;
	logic DramSelect_L, DramWe_L, DramAs_L, DramUds_L, DramLds_L;
	cacheGeometryPkg::addrT DramAddress;
	cacheGeometryPkg::dataT DramWriteData;
	cacheGeometryPkg::dataT DramReadData;
	logic DramDtack_L, DramCas_L, DramRas_L;

	integer seed;					// $random state
	int errorCount = 0;
	int errorsAtStart = 0;				// errors seen before the current test
	int testCount = 0;
	int failedTests = 0;
	cacheGeometryPkg::dataT expectWord;		// word the current read must return
	logic expectHit = 1'b0;				// current read must not touch the DRAM
	logic expectMiss = 1'b0;			// current read must select the DRAM
	cacheGeometryPkg::dataT written [cacheGeometryPkg::addrT];	// words sent to DRAM

	cacheController DUT (.*);
	dramModel dram (.*);

	initial Clock = 1'b0;
	always #50 Clock = ~Clock;

	//////////////////////////////////////////////////
	// checking assertions
	//////////////////////////////////////////////////
	readData: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!CpuDtack_L && CpuWe_L && !CpuAs_L) |-> CpuReadData == expectWord)
		else begin
			errorCount++;
			$display("Fail %0t: read of %h returned %h, expected %h", $time,
				$sampled(CpuAddress), $sampled(CpuReadData), $sampled(expectWord));
		end
	missSelect: assert property (@(posedge Clock) disable iff (!Reset_L)
		(expectMiss && $fell(CpuAs_L)) |=> !DramSelect_L)
		else begin
			errorCount++;
			$display("A read that should miss did not select the DRAM at %0t", $time);
		end
	hitQuiet: assert property (@(posedge Clock) disable iff (!Reset_L)
		(expectHit && !CpuAs_L) |-> DramSelect_L)
		else begin
			errorCount++;
			$display("A read that should hit selected the DRAM at %0t", $time);
		end
	lineAligned: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSelect_L && DramWe_L) |-> DramAddress[3:0] == 4'h0)
		else begin
			errorCount++;
			$display("Fail %0t: DRAM read address %h is not line aligned", $time,
				$sampled(DramAddress));
		end
	readStrobes: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!CpuAs_L && CpuDramSelect && CpuWe_L) |-> (!DramUds_L && !DramLds_L))
		else begin
			errorCount++;
			$display("Fail %0t: DRAM strobes %b%b on a read", $time,
				$sampled(DramUds_L), $sampled(DramLds_L));
		end
	writePass: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!CpuAs_L && CpuDramSelect && !CpuWe_L) |-> (!DramSelect_L &&
		DramAddress == CpuAddress && DramWriteData == CpuWriteData &&
		DramUds_L == CpuUds_L && DramLds_L == CpuLds_L && CpuDtack_L == DramDtack_L))
		else begin
			errorCount++;
			$display("Fail %0t: write to %h was not passed through to the DRAM", $time,
				$sampled(CpuAddress));
		end
	dramFollows: assert property (@(posedge Clock) disable iff (!Reset_L)
		DramAs_L == CpuAs_L && DramWe_L == CpuWe_L)
		else begin
			errorCount++;
			$display("Fail %0t: DRAM AS %b and WE %b do not follow the CPU", $time,
				$sampled(DramAs_L), $sampled(DramWe_L));
		end
	foreignQuiet: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!CpuAs_L && !CpuDramSelect) |-> (CpuDtack_L && DramSelect_L))
		else begin
			errorCount++;
			$display("A cycle outside DRAM space was answered at %0t", $time);
		end

	//////////////////////////////////////////////////
	// expected data and CPU bus cycles
	//////////////////////////////////////////////////
	function automatic cacheGeometryPkg::dataT expectedWord(input cacheGeometryPkg::addrT addr);
		if (written.exists(addr))
			return written[addr];
		return cacheGeometryPkg::dataT'(addr[31:16] ^ addr[15:0] ^ 16'h3C5A);	// DRAM fill
	endfunction

	function automatic cacheGeometryPkg::addrT lineAddress(input cacheGeometryPkg::tagT tag,
		input cacheGeometryPkg::indexT index, input cacheGeometryPkg::wordSelT word);
		return {tag, index, word, 1'b0};
	endfunction

	task automatic waitAck(input string what);
		int clocks;
		clocks = 0;
		do begin
			@(posedge Clock);
			clocks++;
		end while (CpuDtack_L && clocks < AckTimeout);
		if (CpuDtack_L) begin
			$display("No acknowledge for the %s after %0d clocks at %0t", what, clocks, $time);
			$display("Finished with errors");
			$finish;
		end
	endtask

	task automatic readCycle(input cacheGeometryPkg::addrT addr, input logic hit,
		input logic miss, input logic [1:0] strobes);
		CpuAddress <= addr;
		CpuWe_L <= 1'b1;
		CpuUds_L <= strobes[1];		// any strobes, the cache reads whole words
		CpuLds_L <= strobes[0];
		CpuDramSelect <= 1'b1;
		CpuAs_L <= 1'b0;
		expectWord <= expectedWord(addr);
		expectHit <= hit;
		expectMiss <= miss;
		waitAck("read");
		CpuAs_L <= 1'b1;
		expectHit <= 1'b0;
		expectMiss <= 1'b0;
		repeat (2) @(posedge Clock);	// bus idle between cycles
	endtask

	task automatic writeCycle(input cacheGeometryPkg::addrT addr,
		input cacheGeometryPkg::dataT data, input logic [1:0] strobes);
		CpuAddress <= addr;
		CpuWriteData <= data;
		CpuWe_L <= 1'b0;
		CpuUds_L <= strobes[1];
		CpuLds_L <= strobes[0];
		CpuDramSelect <= 1'b1;
		CpuAs_L <= 1'b0;
		written[addr] = data;
		waitAck("write");
		CpuAs_L <= 1'b1;		// WE stays low until the next cycle starts
		repeat (2) @(posedge Clock);
	endtask

	// a request outside DRAM space, held long enough for any wrong answer to show
	task automatic foreignCycle(input cacheGeometryPkg::addrT addr);
		CpuAddress <= addr;
		CpuWe_L <= 1'b1;
		CpuDramSelect <= 1'b0;
		CpuAs_L <= 1'b0;
		repeat (4) @(posedge Clock);
		CpuAs_L <= 1'b1;
		repeat (2) @(posedge Clock);
	endtask

	task automatic reportTest(input string name);
		testCount++;
		if (errorCount == errorsAtStart) begin
			$display("Test %0d, %s: passed", testCount, name);
		end else begin
			failedTests++;
			$display("Test %0d, %s: failed with %0d errors", testCount, name,
				errorCount - errorsAtStart);
		end
		errorsAtStart = errorCount;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		cacheGeometryPkg::tagT tagA;
		cacheGeometryPkg::indexT indexA;
		cacheGeometryPkg::tagT lruBase;		// five tags follow this one
		cacheGeometryPkg::indexT lruIndex;
		cacheGeometryPkg::addrT wordAddr;
		seed = 96;
		Reset_L <= 1'b0;
		CpuAs_L <= 1'b1;
		CpuWe_L <= 1'b1;
		CpuUds_L <= 1'b1;
		CpuLds_L <= 1'b1;
		CpuDramSelect <= 1'b0;
		CpuAddress <= '0;
		CpuWriteData <= '0;
		repeat (4) @(posedge Clock);
		Reset_L <= 1'b1;
		repeat (`CACHE_LINES + 2) @(posedge Clock);	// flush sweeps one line per clock

		tagA = cacheGeometryPkg::tagT'($random(seed));
		indexA = cacheGeometryPkg::indexT'($random(seed));
		wordAddr = lineAddress(tagA, indexA, cacheGeometryPkg::wordSelT'($random(seed)));
		readCycle(wordAddr, 1'b0, 1'b1, 2'($random(seed)));
		foreignCycle(wordAddr);
		reportTest("miss fill");

		for (int i = 0; i < 3; i++)
			readCycle(lineAddress(tagA, indexA, cacheGeometryPkg::wordSelT'($random(seed))),
				1'b1, 1'b0, 2'($random(seed)));
		reportTest("read hit");

		// upper byte lane only into a line that is not cached
		writeCycle(lineAddress(tagA + cacheGeometryPkg::tagT'(1), indexA,
			cacheGeometryPkg::wordSelT'(2)), cacheGeometryPkg::dataT'($random(seed)), 2'b01);
		wordAddr = lineAddress(tagA, indexA, cacheGeometryPkg::wordSelT'(5));
		writeCycle(wordAddr, cacheGeometryPkg::dataT'($random(seed)), 2'b00);
		reportTest("write-through");
		readCycle(wordAddr, 1'b0, 1'b1, 2'b00);	// stale copy is gone, refill brings the new word
		reportTest("write invalidation");

		// a fresh set fills ways 0, 2, 1, 3 and the fifth tag evicts the first
		lruBase = cacheGeometryPkg::tagT'($random(seed));
		lruIndex = cacheGeometryPkg::indexT'(indexA + 4);
		for (int i = 0; i < 5; i++)
			readCycle(lineAddress(lruBase + cacheGeometryPkg::tagT'(i), lruIndex,
				cacheGeometryPkg::wordSelT'(i)), 1'b0, 1'b1, 2'($random(seed)));
		for (int i = 1; i < 4; i++)
			readCycle(lineAddress(lruBase + cacheGeometryPkg::tagT'(i), lruIndex,
				cacheGeometryPkg::wordSelT'(7 - i)), 1'b1, 1'b0, 2'($random(seed)));
		readCycle(lineAddress(lruBase, lruIndex, 3'd6), 1'b0, 1'b1, 2'($random(seed)));
		reportTest("pseudo-LRU replacement");

		for (int s = 0; s < 4; s++)
			readCycle(lineAddress(tagA, indexA, cacheGeometryPkg::wordSelT'(s)), 1'b1, 1'b0,
				2'(s));
		readCycle(lineAddress(lruBase + cacheGeometryPkg::tagT'(4), lruIndex, 3'd7), 1'b0,
			1'b1, 2'b11);	// the fifth tag was evicted by the refill of the first
		reportTest("read strobes");

		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end
endmodule

/* tb.f */
+incdir+src
src/cacheGeometryPkg.sv
src/cacheControlPkg.sv
src/cacheSequencer.sv
src/tagStore.sv
src/lineStore.sv
src/lruTree.sv
src/cacheController.sv
tests/dramModel.sv
tests/cacheControllerTb.sv

/* Bender.yml */
package:
  name: cache_controller

export_include_dirs:
  - src

sources:
  - src/cacheGeometryPkg.sv
  - src/cacheControlPkg.sv
  - src/cacheSequencer.sv
  - src/tagStore.sv
  - src/lineStore.sv
  - src/lruTree.sv
  - src/cacheController.sv
  - target: test
    files:
      - tests/dramModel.sv
      - tests/cacheControllerTb.sv
